//--- hdl/debug_pkg.sv
package debug_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  typedef logic [7:0]  uart_byte_t;        // One byte on the UART link.
  typedef logic [31:0] instr_word_t;       // Instruction or database word.
  typedef logic [10:0] mem_addr_t;         // Program memory address.

  localparam int BYTES_PER_WORD = 4;       // Bytes packed into one word.

  ////////////////////////////////////////
  // Host commands
  ////////////////////////////////////////

  localparam uart_byte_t CMD_SOFT_RESET = 8'h00;
  localparam uart_byte_t CMD_LOAD       = 8'h01;  // Also the reply offered after reset.
  localparam uart_byte_t CMD_RUN        = 8'h03;  // Continuous execution.
  localparam uart_byte_t CMD_STEP       = 8'h07;  // Step by step execution.

  localparam int STEP_MODE_BIT = 2;        // Mode bit inside the start command.

  localparam instr_word_t HALT_WORD = 32'h0000_0000;  // Ends the run and the load.

  localparam int ACK_STRIDE = 8;           // Report ack codes are 8, 16, ... 80.

  // Top level phases of the debug unit.
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_SOFT_RESET,
    PH_WAIT_LOAD_ACK,
    PH_LOAD,
    PH_WAIT_START,
    PH_RUN,
    PH_REPORT
  } phase_t;

  // Report bytes in the order they go out.
  typedef enum logic [3:0] {
    STEP_PC_HI,
    STEP_PC_LO,
    STEP_CYCLES_HI,
    STEP_CYCLES_LO,
    STEP_PC4_HI,
    STEP_PC4_LO,
    STEP_INSTR_B3,
    STEP_INSTR_B2,
    STEP_INSTR_B1,
    STEP_INSTR_B0
  } report_step_t;

  // Selects which word the processor puts on the database bus.
  typedef enum logic [2:0] {
    DB_NONE     = 3'd0,
    DB_RUN      = 3'd1,
    DB_PC       = 3'd2,
    DB_CYCLES   = 3'd3,
    DB_PC_PLUS4 = 3'd4,
    DB_INSTR    = 3'd5
  } db_sel_t;

endpackage

//--- hdl/debug_if.sv
`timescale 1ns/1ps

// Internal links between the sequencer, the loader and the reporter.
interface debug_if;

  logic                  byte_strobe;    // One cycle per received byte.
  debug_pkg::uart_byte_t byte_data;      // Valid with byte_strobe.
  logic                  load_enable;    // High for the whole load phase.
  logic                  report_active;  // High for the whole report phase.
  logic                  run_active;     // High while the PC runs.
  logic                  load_done;      // Terminator word seen.
  logic                  report_done;    // Last report byte acknowledged.

  modport sequencer (
    output byte_strobe, byte_data, load_enable, report_active, run_active,
    input  load_done, report_done
  );

  modport loader (
    input  byte_strobe, byte_data, load_enable,
    output load_done
  );

  modport reporter (
    input  byte_strobe, byte_data, report_active, run_active,
    output report_done
  );

endinterface

//--- hdl/debug_sequencer.sv
`timescale 1ns/1ps

module debug_sequencer (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_rx_done,
  input  debug_pkg::uart_byte_t  i_data_rx,
  input  logic                   i_soft_reset_ack,
  input  debug_pkg::instr_word_t i_instruction_fetch,
  output logic                   o_soft_reset,
  output logic                   o_enable_pc,
  output logic                   o_step_mode,
  output logic                   o_tx_start_ack,
  debug_if.sequencer             bus
);

  logic              rx_done_q;       // Previous i_rx_done.
  logic              byte_strobe;
  logic              start_cmd;
  debug_pkg::phase_t phase_q;
  debug_pkg::phase_t phase_d;

  ////////////////////////////////////////
  // Receive strobe
  ////////////////////////////////////////

  // The UART done flag falls once per byte; that edge marks a fresh byte.
  assign byte_strobe = rx_done_q & ~i_rx_done;

  assign start_cmd = byte_strobe &&
                     ((i_data_rx == debug_pkg::CMD_RUN) || (i_data_rx == debug_pkg::CMD_STEP));

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rx_done_q <= 1'b0;
    end else begin
      rx_done_q <= i_rx_done;
    end
  end

  ////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      debug_pkg::PH_IDLE: begin
        if (byte_strobe && (i_data_rx == debug_pkg::CMD_SOFT_RESET)) begin
          phase_d = debug_pkg::PH_SOFT_RESET;
        end
      end
      debug_pkg::PH_SOFT_RESET: begin
        if (!i_soft_reset_ack) begin           // Ack is active low.
          phase_d = debug_pkg::PH_WAIT_LOAD_ACK;
        end
      end
      debug_pkg::PH_WAIT_LOAD_ACK: begin
        if (byte_strobe && (i_data_rx == debug_pkg::CMD_LOAD)) begin
          phase_d = debug_pkg::PH_LOAD;
        end
      end
      debug_pkg::PH_LOAD: begin
        if (bus.load_done) begin
          phase_d = debug_pkg::PH_WAIT_START;
        end
      end
      debug_pkg::PH_WAIT_START: begin
        if (start_cmd) begin
          phase_d = debug_pkg::PH_RUN;
        end
      end
      debug_pkg::PH_RUN: begin
        if (i_instruction_fetch == debug_pkg::HALT_WORD) begin
          phase_d = debug_pkg::PH_REPORT;
        end
      end
      debug_pkg::PH_REPORT: begin
        if (bus.report_done) begin
          phase_d = debug_pkg::PH_IDLE;
        end
      end
      default: begin
        phase_d = debug_pkg::PH_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      phase_q     <= debug_pkg::PH_IDLE;
      o_step_mode <= 1'b0;                     // Continuous.
    end else begin
      phase_q <= phase_d;
      if ((phase_q == debug_pkg::PH_WAIT_START) && start_cmd) begin
        o_step_mode <= i_data_rx[debug_pkg::STEP_MODE_BIT];
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign o_soft_reset   = (phase_q != debug_pkg::PH_SOFT_RESET);  // Active low.
  assign o_enable_pc    = (phase_q == debug_pkg::PH_RUN);
  assign o_tx_start_ack = (phase_q == debug_pkg::PH_WAIT_LOAD_ACK);

  assign bus.byte_strobe   = byte_strobe;
  assign bus.byte_data     = i_data_rx;
  assign bus.load_enable   = (phase_q == debug_pkg::PH_LOAD);
  assign bus.report_active = (phase_q == debug_pkg::PH_REPORT);
  assign bus.run_active    = (phase_q == debug_pkg::PH_RUN);

endmodule

//--- hdl/program_loader.sv
`timescale 1ns/1ps

module program_loader (
  input  logic                   i_clock,
  input  logic                   i_reset,
  debug_if.loader                bus,
  output logic                   o_mem_write,
  output debug_pkg::mem_addr_t   o_mem_addr,
  output debug_pkg::instr_word_t o_mem_data
);

  logic [1:0]             byte_cnt_q;   // Bytes already in the current word.
  logic                   done_q;
  logic                   byte_in;
  logic                   word_full;
  debug_pkg::instr_word_t next_word;

  ////////////////////////////////////////
  // Byte packing
  ////////////////////////////////////////

  assign byte_in = bus.load_enable && bus.byte_strobe;

  // First byte of a word ends up on top.
  assign next_word = {o_mem_data[23:0], bus.byte_data};

  assign word_full = byte_in && (byte_cnt_q == 2'(debug_pkg::BYTES_PER_WORD - 1));

  always_ff @(posedge i_clock) begin
    if (byte_in) begin
      o_mem_data <= next_word;
    end
  end

  ////////////////////////////////////////
  // Write port and terminator
  ////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset || !bus.load_enable) begin
      byte_cnt_q  <= 2'd0;
      o_mem_addr  <= '0;
      o_mem_write <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      // Full word is written on the cycle after its last byte.
      o_mem_write <= word_full && (next_word != debug_pkg::HALT_WORD);
      done_q      <= word_full && (next_word == debug_pkg::HALT_WORD);
      if (byte_in) begin
        byte_cnt_q <= byte_cnt_q + 2'd1;       // Wraps after four bytes.
      end
      if (o_mem_write) begin
        o_mem_addr <= o_mem_addr + 1'b1;       // Next free location.
      end
    end
  end

  assign bus.load_done = done_q;

endmodule

//--- hdl/report_sender.sv
`timescale 1ns/1ps

module report_sender (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  debug_pkg::instr_word_t i_database_word,
  debug_if.reporter              bus,
  output logic                   o_tx_start_rep,
  output debug_pkg::uart_byte_t  o_data_tx_rep,
  output debug_pkg::db_sel_t     o_db_sel
);

  debug_pkg::report_step_t step_q;
  debug_pkg::uart_byte_t   ack_code;
  logic [1:0]              byte_idx;    // Byte of the database word on the link.
  logic                    ack_hit;

  // Host acks step n (from 1) with n * 8.
  assign ack_code = debug_pkg::uart_byte_t'(({4'd0, step_q} + 8'd1) * debug_pkg::ACK_STRIDE);

  assign ack_hit = bus.report_active && bus.byte_strobe && (bus.byte_data == ack_code);

  assign bus.report_done = ack_hit && (step_q == debug_pkg::STEP_INSTR_B0);

  always_ff @(posedge i_clock) begin
    if (!i_reset || !bus.report_active) begin
      step_q <= debug_pkg::STEP_PC_HI;
    end else if (ack_hit) begin
      if (step_q == debug_pkg::STEP_INSTR_B0) begin
        step_q <= debug_pkg::STEP_PC_HI;
      end else begin
        step_q <= debug_pkg::report_step_t'(step_q + 4'd1);
      end
    end
  end

  ////////////////////////////////////////
  // Selector and byte choice
  ////////////////////////////////////////

  always_comb begin
    o_db_sel = debug_pkg::DB_NONE;
    byte_idx = 2'd0;
    if (bus.report_active) begin
      case (step_q)
        debug_pkg::STEP_PC_HI,     debug_pkg::STEP_PC_LO:     o_db_sel = debug_pkg::DB_PC;
        debug_pkg::STEP_CYCLES_HI, debug_pkg::STEP_CYCLES_LO: o_db_sel = debug_pkg::DB_CYCLES;
        debug_pkg::STEP_PC4_HI,    debug_pkg::STEP_PC4_LO:    o_db_sel = debug_pkg::DB_PC_PLUS4;
        default:                                              o_db_sel = debug_pkg::DB_INSTR;
      endcase
      case (step_q)
        debug_pkg::STEP_PC_HI,
        debug_pkg::STEP_CYCLES_HI,
        debug_pkg::STEP_PC4_HI:    byte_idx = 2'd1;   // High half of a 16-bit pair.
        debug_pkg::STEP_INSTR_B3:  byte_idx = 2'd3;
        debug_pkg::STEP_INSTR_B2:  byte_idx = 2'd2;
        debug_pkg::STEP_INSTR_B1:  byte_idx = 2'd1;
        default:                   byte_idx = 2'd0;
      endcase
    end else if (bus.run_active) begin
      o_db_sel = debug_pkg::DB_RUN;
    end
  end

  assign o_tx_start_rep = bus.report_active;     // Held until the host acks.
  assign o_data_tx_rep  = bus.report_active ? i_database_word[byte_idx * 8 +: 8] : 8'h00;

endmodule

//--- hdl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_rx_done,
  input  debug_pkg::uart_byte_t  i_data_rx,
  input  logic                   i_soft_reset_ack,
  input  debug_pkg::instr_word_t i_instruction_fetch,
  input  debug_pkg::instr_word_t i_database_word,
  output logic                   o_tx_start,
  output debug_pkg::uart_byte_t  o_data_tx,
  output logic                   o_soft_reset,
  output logic                   o_mem_write,
  output debug_pkg::mem_addr_t   o_mem_addr,
  output debug_pkg::instr_word_t o_mem_data,
  output logic                   o_step_mode,
  output logic                   o_enable_pc,
  output debug_pkg::db_sel_t     o_db_sel
);

  logic                  tx_start_ack;   // Offer of 0x01 after soft reset.
  logic                  tx_start_rep;   // Report byte offered.
  debug_pkg::uart_byte_t data_tx_rep;

  debug_if dbg_bus ();

  debug_sequencer u_sequencer (
    .i_clock             (i_clock),
    .i_reset             (i_reset),
    .i_rx_done           (i_rx_done),
    .i_data_rx           (i_data_rx),
    .i_soft_reset_ack    (i_soft_reset_ack),
    .i_instruction_fetch (i_instruction_fetch),
    .o_soft_reset        (o_soft_reset),
    .o_enable_pc         (o_enable_pc),
    .o_step_mode         (o_step_mode),
    .o_tx_start_ack      (tx_start_ack),
    .bus                 (dbg_bus.sequencer)
  );

  program_loader u_loader (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .bus         (dbg_bus.loader),
    .o_mem_write (o_mem_write),
    .o_mem_addr  (o_mem_addr),
    .o_mem_data  (o_mem_data)
  );

  report_sender u_reporter (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_database_word (i_database_word),
    .bus             (dbg_bus.reporter),
    .o_tx_start_rep  (tx_start_rep),
    .o_data_tx_rep   (data_tx_rep),
    .o_db_sel        (o_db_sel)
  );

  // Only one of the two sources is active in any phase.
  assign o_tx_start = tx_start_ack | tx_start_rep;
  assign o_data_tx  = tx_start_ack ? debug_pkg::CMD_LOAD : data_tx_rep;

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clock,
  output logic o_reset
);

  localparam int RESET_CYCLES = 16;

  initial begin
    o_clock = 1'b0;
    forever #2 o_clock = ~o_clock;             // 4 ns period.
  end

  initial begin
    o_reset = 1'b0;                            // Active low.
    repeat (RESET_CYCLES) @(posedge o_clock);
    o_reset <= 1'b1;
  end

endmodule

//--- verification/debug_unit_sva.sv
`timescale 1ns/1ps

module debug_unit_sva (
  input logic i_clock,
  input logic i_reset,
  input logic i_load_enable,
  input logic i_mem_write,
  input logic i_enable_pc,
  input logic i_tx_start,
  input logic i_soft_reset
);

  // Writes only while a program is loading.
  a_write_in_load : assert property (@(posedge i_clock) disable iff (!i_reset)
    i_mem_write |-> i_load_enable)
    else $error("program memory written outside the load phase");

  a_run_or_tx : assert property (@(posedge i_clock) disable iff (!i_reset)
    !(i_enable_pc && i_tx_start))
    else $error("PC enabled while a byte is offered");

  // Processor held in reset cannot run.
  a_reset_stops_pc : assert property (@(posedge i_clock) disable iff (!i_reset)
    !i_soft_reset |-> !i_enable_pc)
    else $error("PC enabled during soft reset");

endmodule

bind debug_unit debug_unit_sva u_sva (
  .i_clock       (i_clock),
  .i_reset       (i_reset),
  .i_load_enable (dbg_bus.load_enable),
  .i_mem_write   (o_mem_write),
  .i_enable_pc   (o_enable_pc),
  .i_tx_start    (o_tx_start),
  .i_soft_reset  (o_soft_reset)
);

//--- verification/debug_unit_tb.sv
`timescale 1ns/1ps

module debug_unit_tb;

  localparam int TIMEOUT    = 200;           // Cycles allowed for any wait.
  localparam int N_SCEN     = 3;
  localparam int SIG_RESET  = 0;
  localparam int SIG_TX     = 1;
  localparam int SIG_ENABLE = 2;

  typedef struct {
    string                  name;
    debug_pkg::instr_word_t prog [4];
    int                     n_words;
    debug_pkg::uart_byte_t  start_cmd;
    int                     run_cycles;
    int                     bad_step;      // Report step that gets a wrong ack.
  } scenario_t;

  logic                   clock;
  logic                   reset;
  logic                   rx_done;
  debug_pkg::uart_byte_t  data_rx;
  logic                   soft_reset_ack;
  debug_pkg::instr_word_t instruction_fetch;
  debug_pkg::instr_word_t database_word;
  logic                   tx_start;
  debug_pkg::uart_byte_t  data_tx;
  logic                   soft_reset;
  logic                   mem_write;
  debug_pkg::mem_addr_t   mem_addr;
  debug_pkg::instr_word_t mem_data;
  logic                   step_mode;
  logic                   enable_pc;
  debug_pkg::db_sel_t     db_sel;

  scenario_t              scen [N_SCEN];
  debug_pkg::mem_addr_t   wr_addr [$];
  debug_pkg::instr_word_t wr_data [$];
  int                     low_cycles;
  int unsigned            seed;

  tb_clock_gen u_clock (.o_clock(clock), .o_reset(reset));

  debug_unit dut (
    .i_clock(clock), .i_reset(reset), .i_rx_done(rx_done), .i_data_rx(data_rx),
    .i_soft_reset_ack(soft_reset_ack), .i_instruction_fetch(instruction_fetch),
    .i_database_word(database_word), .o_tx_start(tx_start), .o_data_tx(data_tx),
    .o_soft_reset(soft_reset), .o_mem_write(mem_write), .o_mem_addr(mem_addr),
    .o_mem_data(mem_data), .o_step_mode(step_mode), .o_enable_pc(enable_pc),
    .o_db_sel(db_sel)
  );

  ////////////////////////////////////////
  // Processor model
  ////////////////////////////////////////

  function automatic debug_pkg::instr_word_t db_value(input debug_pkg::db_sel_t sel);
    case (sel)
      debug_pkg::DB_RUN:      return 32'h0000_00AA;
      debug_pkg::DB_PC:       return 32'h0000_1A2C;
      debug_pkg::DB_CYCLES:   return 32'h0000_0345;
      debug_pkg::DB_PC_PLUS4: return 32'h0000_1A30;
      debug_pkg::DB_INSTR:    return 32'h8C22_0004;
      default:                return 32'h0000_0000;
    endcase
  endfunction

  always @(posedge clock) begin
    database_word <= db_value(db_sel);        // Registered database bus.
    if (mem_write) begin
      wr_addr.push_back(mem_addr);
      wr_data.push_back(mem_data);
    end
    // Acknowledge the soft reset three cycles late.
    if (!soft_reset) begin
      low_cycles <= low_cycles + 1;
      if (low_cycles == 2) soft_reset_ack <= 1'b0;
    end else begin
      low_cycles     <= 0;
      soft_reset_ack <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input debug_pkg::uart_byte_t exp,
                            input debug_pkg::uart_byte_t act);
    if (exp !== act) fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input debug_pkg::instr_word_t exp,
                            input debug_pkg::instr_word_t act);
    if (exp !== act) fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input debug_pkg::mem_addr_t exp,
                            input debug_pkg::mem_addr_t act);
    if (exp !== act) fail_now($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) fail_now($sformatf("mismatch %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_sel(input string name, input debug_pkg::db_sel_t exp,
                           input debug_pkg::db_sel_t act);
    if (exp !== act) fail_now($sformatf("mismatch %s expected %s actual %s",
                                        name, exp.name(), act.name()));
  endtask

  task automatic wait_signal(input int which, input logic level, input string what);
    logic seen;
    for (int n = 0; n <= TIMEOUT; n++) begin
      @(negedge clock);
      case (which)
        SIG_RESET: seen = soft_reset;
        SIG_TX:    seen = tx_start;
        default:   seen = enable_pc;
      endcase
      if (seen === level) return;
    end
    fail_now($sformatf("timed out waiting for %s", what));
  endtask

  // Sends one host byte with a pulsed done flag and a random gap.
  task automatic send_byte(input debug_pkg::uart_byte_t b);
    int gap;
    gap = 2 + $urandom_range(2);
    @(posedge clock);
    rx_done <= 1'b1;
    data_rx <= b;
    @(posedge clock);
    rx_done <= 1'b0;
    repeat (gap) @(posedge clock);
  endtask

  function automatic debug_pkg::db_sel_t step_sel(input int k);
    if (k < 2) return debug_pkg::DB_PC;
    if (k < 4) return debug_pkg::DB_CYCLES;
    if (k < 6) return debug_pkg::DB_PC_PLUS4;
    return debug_pkg::DB_INSTR;
  endfunction

  // Pairs go high byte first, the instruction from byte 3 down.
  function automatic debug_pkg::uart_byte_t step_byte(input int k);
    debug_pkg::instr_word_t w;
    w = db_value(step_sel(k));
    if (k < 6) return (k % 2 == 0) ? w[15:8] : w[7:0];
    return w[(9 - k) * 8 +: 8];
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    string              nm;
    debug_pkg::uart_byte_t held_data;
    debug_pkg::db_sel_t held_sel;
    seed = $urandom(32'h4311);
    rx_done           <= 1'b0;
    data_rx           <= 8'h00;
    soft_reset_ack    <= 1'b1;
    instruction_fetch <= 32'hFFFF_FFFF;
    database_word     <= 32'h0;
    low_cycles        <= 0;
    scen[0] = '{"single_run", '{32'h2001_0005, 32'h2002_0007, 0, 0}, 2, 8'h03, 4, 3};
    scen[1] = '{"step_mode", '{32'h8C22_0004, 0, 0, 0}, 1, 8'h07, 2, 0};
    scen[2] = '{"full_prog", '{32'h0000_0001, 32'hFF00_00FF, 32'h1234_5678, 32'hA5A5_5A5A},
                4, 8'h03, 7, 9};
    for (int n = 0; n <= TIMEOUT && reset !== 1'b1; n++) @(posedge clock);
    if (reset !== 1'b1) fail_now("reset never released");

    for (int s = 0; s < N_SCEN; s++) begin
      nm = scen[s].name;
      send_byte(debug_pkg::CMD_SOFT_RESET);
      wait_signal(SIG_RESET, 1'b0, "soft reset to go low");
      wait_signal(SIG_RESET, 1'b1, "soft reset to be released");
      check_bit({nm, " ack before release"}, 1'b0, soft_reset_ack);
      check_bit({nm, " offer"}, 1'b1, tx_start);
      check_byte({nm, " offer"}, 8'h01, data_tx);

      wr_addr.delete();
      wr_data.delete();
      send_byte(debug_pkg::CMD_LOAD);
      for (int w = 0; w <= scen[s].n_words; w++) begin
        for (int b = 0; b < 4; b++) begin
          send_byte((w < scen[s].n_words) ? scen[s].prog[w][31 - 8 * b -: 8] : 8'h00);
        end
      end
      check_addr({nm, " write count"}, scen[s].n_words, wr_addr.size());
      foreach (wr_addr[i]) begin
        check_addr({nm, " write addr"}, i, wr_addr[i]);
        check_word({nm, " write data"}, scen[s].prog[i], wr_data[i]);
      end

      instruction_fetch <= 32'h2000_0000 + s;
      send_byte(scen[s].start_cmd);
      check_bit({nm, " step mode"}, scen[s].start_cmd[2], step_mode);
      for (int c = 0; c < scen[s].run_cycles; c++) begin
        @(negedge clock);
        check_bit({nm, " enable pc"}, 1'b1, enable_pc);
        check_sel({nm, " run sel"}, debug_pkg::DB_RUN, db_sel);
      end
      @(posedge clock);
      instruction_fetch <= debug_pkg::HALT_WORD;
      wait_signal(SIG_ENABLE, 1'b0, "PC to stop after HALT");
      @(posedge clock);
      instruction_fetch <= 32'hFFFF_FFFF;
      wait_signal(SIG_TX, 1'b1, "first report byte");
      @(posedge clock);

      for (int k = 0; k < 10; k++) begin
        @(negedge clock);
        check_sel($sformatf("%s report sel %0d", nm, k), step_sel(k), db_sel);
        check_byte($sformatf("%s report byte %0d", nm, k), step_byte(k), data_tx);
        if (k == scen[s].bad_step) begin
          held_data = data_tx;
          held_sel  = db_sel;
          send_byte(8'((k + 1) * 8 + 3));
          @(negedge clock);
          check_byte({nm, " after wrong ack"}, held_data, data_tx);
          check_sel({nm, " after wrong ack"}, held_sel, db_sel);
        end
        send_byte(8'((k + 1) * 8));
      end
      @(negedge clock);
      check_bit({nm, " idle tx"}, 1'b0, tx_start);
      check_sel({nm, " idle sel"}, debug_pkg::DB_NONE, db_sel);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- src.f
hdl/debug_pkg.sv
hdl/debug_if.sv
hdl/debug_sequencer.sv
hdl/program_loader.sv
hdl/report_sender.sv
hdl/debug_unit.sv
verification/tb_clock_gen.sv
verification/debug_unit_sva.sv
verification/debug_unit_tb.sv
